// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_pbs_entry_subs
FILE_LIST ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "SOME TESTS FAILED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: all.f
+incdir+design
design/pbs_pkg.sv
design/glwe_ram.sv
design/glwe_loader.sv
design/mono_mult_acc.sv
design/decomp_balanced.sv
design/pbs_entry_subs.sv
testbench/tb_clk_gen.sv
testbench/tb_pbs_entry_subs.sv

// File: design/decomp_balanced.sv
`timescale 1ns/100ps
`include "pbs_consts.svh"

module decomp_balanced
  import pbs_pkg::*;
(
  input  logic    clk,
  input  logic    s_rst_n,
  input  logic    acc_decomp_avail,
  input  coef_t   acc_decomp_data,
  input  logic    acc_decomp_sol,
  input  logic    acc_decomp_eol,
  input  pbs_id_t acc_decomp_pbs_id,
  output logic    decomp_ntt_avail,
  output decomp_t decomp_ntt_data,
  output logic    decomp_ntt_sol,
  output logic    decomp_ntt_eol,
  output pbs_id_t decomp_ntt_pbs_id
);

  localparam int ROUND_W = `PBS_L * `PBS_B_W;
  localparam int DROP_W  = `PBS_MOD_Q_W - ROUND_W;

  logic [ROUND_W-1:0] rounded;
  decomp_t            digits;
  logic [ROUND_W-1:0] recomposed;

  // Top bits, rounded on the first dropped bit
  assign rounded = acc_decomp_data[`PBS_MOD_Q_W-1 -: ROUND_W]
                 + ROUND_W'(acc_decomp_data[DROP_W-1]);

  always_comb begin : digit_calc
    logic [`PBS_B_W-1:0] chunk;
    logic                carry;
    carry = 1'b0;
    for (int l = 0; l < `PBS_L; l++) begin
      chunk     = rounded[l*`PBS_B_W +: `PBS_B_W] + `PBS_B_W'(carry);
      // Upper half of the base becomes chunk - 2^B and carries
      digits[l] = {chunk[`PBS_B_W-1], chunk};
      carry     = chunk[`PBS_B_W-1];
    end
  end

  // Signed digits weighted by the base give back the rounded value
  always_comb begin : recompose
    recomposed = '0;
    for (int l = 0; l < `PBS_L; l++) begin
      recomposed = recomposed
                 + ({{(ROUND_W-`PBS_B_W-1){digits[l][`PBS_B_W]}}, digits[l]}
                    << (l*`PBS_B_W));
    end
  end

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      decomp_ntt_avail <= 1'b0;
      decomp_ntt_sol   <= 1'b0;
      decomp_ntt_eol   <= 1'b0;
    end else begin
      decomp_ntt_avail <= acc_decomp_avail;
      decomp_ntt_sol   <= acc_decomp_sol;
      decomp_ntt_eol   <= acc_decomp_eol;
    end
  end

  always_ff @(posedge clk) begin
    decomp_ntt_data   <= digits;
    decomp_ntt_pbs_id <= acc_decomp_pbs_id;
  end

  a_recompose : assert property (@(posedge clk) disable iff (!s_rst_n)
    acc_decomp_avail |-> (recomposed == rounded));

endmodule

// File: design/glwe_loader.sv
`timescale 1ns/100ps
`include "pbs_consts.svh"

module glwe_loader
  import pbs_pkg::*;
(
  input  logic     clk,
  input  logic     s_rst_n,
  input  logic     cmd_vld,
  input  slot_t    cmd_slot,
  input  logic     data_vld,
  input  coef_t    data,
  output logic     cmd_done,
  output logic     wr_en,
  output ram_add_t wr_add,
  output coef_t    wr_data,
  output logic     counter_inc,
  output logic     cmd_ovf,
  output logic     data_unexp
);

  ldg_state_e state;
  slot_t      slot_q;
  coef_idx_t  idx;
  logic       last_wr;

  // ------------------------------
  // RAM write side
  // ------------------------------
  assign wr_en   = (state == LDG_DATA) && data_vld;
  assign wr_add  = '{slot: slot_q, idx: idx};
  assign wr_data = data;
  assign last_wr = wr_en && (idx == coef_idx_t'(`PBS_N-1));

  // Error and counter pulses, registered by the top
  assign counter_inc = last_wr;
  assign cmd_ovf     = (state == LDG_DATA) && cmd_vld;
  assign data_unexp  = (state == LDG_IDLE) && data_vld;

  // ------------------------------
  // Load FSM
  // ------------------------------
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      state    <= LDG_IDLE;
      idx      <= '0;
      cmd_done <= 1'b0;
    end else begin
      cmd_done <= last_wr;
      case (state)
        LDG_IDLE: begin
          if (cmd_vld) begin
            state <= LDG_DATA;
            idx   <= '0;
          end
        end
        LDG_DATA: begin
          if (wr_en) begin
            idx <= idx + 1'b1;
            if (last_wr) begin
              state <= LDG_IDLE;
            end
          end
        end
        default: state <= LDG_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == LDG_IDLE && cmd_vld) begin
      slot_q <= cmd_slot;
    end
  end

  // Done only once the FSM is back in idle with the index wrapped
  a_done_idle : assert property (@(posedge clk) disable iff (!s_rst_n)
    cmd_done |-> (state == LDG_IDLE) && (idx == '0));

endmodule

// File: design/glwe_ram.sv
`timescale 1ns/100ps
`include "pbs_consts.svh"

module glwe_ram
  import pbs_pkg::*;
(
  input  logic     clk,
  input  logic     wr_en,
  input  ram_add_t wr_add,
  input  coef_t    wr_data,
  input  ram_add_t rd0_add,
  input  ram_add_t rd1_add,
  output coef_t    rd0_data,
  output coef_t    rd1_data
);

  // One word per coefficient of every slot
  coef_t mem [`PBS_SLOT_NB*`PBS_N];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_add] <= wr_data;
    end
  end

  // Both read ports answer one cycle after the address
  always_ff @(posedge clk) begin
    rd0_data <= mem[rd0_add];
    rd1_data <= mem[rd1_add];
  end

endmodule

// File: design/mono_mult_acc.sv
`timescale 1ns/100ps
`include "pbs_consts.svh"

module mono_mult_acc
  import pbs_pkg::*;
(
  input  logic     clk,
  input  logic     s_rst_n,
  input  logic     cmd_vld,
  input  slot_t    cmd_slot,
  input  rot_t     cmd_rot,
  input  pbs_id_t  cmd_pbs_id,
  output logic     cmd_ack,
  output ram_add_t rd0_add,
  output ram_add_t rd1_add,
  input  coef_t    rd0_data,
  input  coef_t    rd1_data,
  output logic     acc_decomp_avail,
  output coef_t    acc_decomp_data,
  output logic     acc_decomp_sol,
  output logic     acc_decomp_eol,
  output pbs_id_t  acc_decomp_pbs_id,
  output logic     cmd_ovf
);

  localparam int IDX_W = $clog2(`PBS_N);

  mmacc_state_e state;
  coef_idx_t    idx;
  slot_t        slot_q;
  rot_t         rot_q;
  pbs_id_t      pbs_id_q;
  logic         accept;
  coef_idx_t    src_idx;
  logic         neg_s0;
  logic         avail_s1;
  logic         sol_s1;
  logic         eol_s1;
  logic         neg_s1;
  pbs_id_t      pbs_id_s1;
  coef_t        rot_coef;

  assign accept  = cmd_vld && (state == MMACC_IDLE);
  assign cmd_ovf = cmd_vld && (state == MMACC_RUN);

  // ------------------------------
  // Negacyclic source index
  // ------------------------------
  // Wrapping below 0 flips the sign, the top rotation bit flips it again
  assign src_idx = idx - rot_q[IDX_W-1:0];
  assign neg_s0  = (idx < rot_q[IDX_W-1:0]) ^ rot_q[IDX_W];

  assign rd0_add = '{slot: slot_q, idx: src_idx};
  assign rd1_add = '{slot: slot_q, idx: idx};

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      state   <= MMACC_IDLE;
      idx     <= '0;
      cmd_ack <= 1'b0;
    end else begin
      cmd_ack <= accept;
      case (state)
        MMACC_IDLE: begin
          if (accept) begin
            state <= MMACC_RUN;
            idx   <= '0;
          end
        end
        MMACC_RUN: begin
          idx <= idx + 1'b1;
          if (idx == coef_idx_t'(`PBS_N-1)) begin
            state <= MMACC_IDLE;
          end
        end
        default: state <= MMACC_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      slot_q   <= cmd_slot;
      rot_q    <= cmd_rot;
      pbs_id_q <= cmd_pbs_id;
    end
  end

  // ------------------------------
  // Read and subtract pipe
  // ------------------------------
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      avail_s1         <= 1'b0;
      sol_s1           <= 1'b0;
      eol_s1           <= 1'b0;
      acc_decomp_avail <= 1'b0;
      acc_decomp_sol   <= 1'b0;
      acc_decomp_eol   <= 1'b0;
    end else begin
      avail_s1         <= (state == MMACC_RUN);
      sol_s1           <= (state == MMACC_RUN) && (idx == '0);
      eol_s1           <= (state == MMACC_RUN) && (idx == coef_idx_t'(`PBS_N-1));
      acc_decomp_avail <= avail_s1;
      acc_decomp_sol   <= sol_s1;
      acc_decomp_eol   <= eol_s1;
    end
  end

  // Product with (X^p - 1), all mod 2^16
  assign rot_coef = neg_s1 ? coef_t'(-rd0_data) : rd0_data;

  always_ff @(posedge clk) begin
    neg_s1            <= neg_s0;
    pbs_id_s1         <= pbs_id_q;
    acc_decomp_data   <= rot_coef - rd1_data;
    acc_decomp_pbs_id <= pbs_id_s1;
  end

  a_stream_len : assert property (@(posedge clk) disable iff (!s_rst_n)
    accept |-> ##3 acc_decomp_avail [*`PBS_N] ##1 !acc_decomp_avail);

endmodule

// File: design/pbs_consts.svh
`ifndef PBS_CONSTS_SVH
`define PBS_CONSTS_SVH

// ------------------------------
// Polynomial geometry
// ------------------------------
// Coefficients per polynomial
`define PBS_N 16
// Coefficient width, modulus is 2^16 so arithmetic wraps
`define PBS_MOD_Q_W 16
// GLWE slots in the local RAM
`define PBS_SLOT_NB 2

// ------------------------------
// Decomposition
// ------------------------------
`define PBS_B_W 4
`define PBS_L 2
`define PBS_ID_W 4

`endif

// File: design/pbs_entry_subs.sv
`timescale 1ns/100ps

module pbs_entry_subs
  import pbs_pkg::*;
(
  input  logic       clk,
  input  logic       s_rst_n,
  input  logic       ldg_cmd_vld,
  input  slot_t      ldg_cmd_slot,
  input  logic       ldg_data_vld,
  input  coef_t      ldg_data,
  output logic       ldg_cmd_done,
  input  logic       mmacc_cmd_vld,
  input  slot_t      mmacc_cmd_slot,
  input  rot_t       mmacc_cmd_rot,
  input  pbs_id_t    mmacc_cmd_pbs_id,
  output logic       mmacc_cmd_ack,
  output logic       decomp_ntt_avail,
  output decomp_t    decomp_ntt_data,
  output logic       decomp_ntt_sol,
  output logic       decomp_ntt_eol,
  output pbs_id_t    decomp_ntt_pbs_id,
  output logic       pep_counter_inc,
  output pep_error_t pep_error
);

  logic       gram_wr_en;
  ram_add_t   gram_wr_add;
  coef_t      gram_wr_data;
  ram_add_t   gram_rd0_add;
  ram_add_t   gram_rd1_add;
  coef_t      gram_rd0_data;
  coef_t      gram_rd1_data;
  logic       acc_decomp_avail;
  coef_t      acc_decomp_data;
  logic       acc_decomp_sol;
  logic       acc_decomp_eol;
  pbs_id_t    acc_decomp_pbs_id;
  logic       ldg_counter_inc;
  logic       ldg_cmd_ovf;
  logic       ldg_data_unexp;
  logic       mmacc_cmd_ovf;
  pep_error_t error_d;

  // ------------------------------
  // Register interface outputs
  // ------------------------------
  always_comb begin
    error_d                = '0;
    error_d.ldg_cmd_ovf    = ldg_cmd_ovf;
    error_d.ldg_data_unexp = ldg_data_unexp;
    error_d.mmacc_cmd_ovf  = mmacc_cmd_ovf;
  end

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      pep_error       <= '0;
      pep_counter_inc <= 1'b0;
    end else begin
      pep_error       <= error_d;
      pep_counter_inc <= ldg_counter_inc;
    end
  end

  glwe_ram i_glwe_ram (
    .clk      (clk),
    .wr_en    (gram_wr_en),
    .wr_add   (gram_wr_add),
    .wr_data  (gram_wr_data),
    .rd0_add  (gram_rd0_add),
    .rd1_add  (gram_rd1_add),
    .rd0_data (gram_rd0_data),
    .rd1_data (gram_rd1_data)
  );

  glwe_loader i_glwe_loader (
    .clk         (clk),
    .s_rst_n     (s_rst_n),
    .cmd_vld     (ldg_cmd_vld),
    .cmd_slot    (ldg_cmd_slot),
    .data_vld    (ldg_data_vld),
    .data        (ldg_data),
    .cmd_done    (ldg_cmd_done),
    .wr_en       (gram_wr_en),
    .wr_add      (gram_wr_add),
    .wr_data     (gram_wr_data),
    .counter_inc (ldg_counter_inc),
    .cmd_ovf     (ldg_cmd_ovf),
    .data_unexp  (ldg_data_unexp)
  );

  mono_mult_acc i_mono_mult_acc (
    .clk               (clk),
    .s_rst_n           (s_rst_n),
    .cmd_vld           (mmacc_cmd_vld),
    .cmd_slot          (mmacc_cmd_slot),
    .cmd_rot           (mmacc_cmd_rot),
    .cmd_pbs_id        (mmacc_cmd_pbs_id),
    .cmd_ack           (mmacc_cmd_ack),
    .rd0_add           (gram_rd0_add),
    .rd1_add           (gram_rd1_add),
    .rd0_data          (gram_rd0_data),
    .rd1_data          (gram_rd1_data),
    .acc_decomp_avail  (acc_decomp_avail),
    .acc_decomp_data   (acc_decomp_data),
    .acc_decomp_sol    (acc_decomp_sol),
    .acc_decomp_eol    (acc_decomp_eol),
    .acc_decomp_pbs_id (acc_decomp_pbs_id),
    .cmd_ovf           (mmacc_cmd_ovf)
  );

  decomp_balanced i_decomp_balanced (
    .clk               (clk),
    .s_rst_n           (s_rst_n),
    .acc_decomp_avail  (acc_decomp_avail),
    .acc_decomp_data   (acc_decomp_data),
    .acc_decomp_sol    (acc_decomp_sol),
    .acc_decomp_eol    (acc_decomp_eol),
    .acc_decomp_pbs_id (acc_decomp_pbs_id),
    .decomp_ntt_avail  (decomp_ntt_avail),
    .decomp_ntt_data   (decomp_ntt_data),
    .decomp_ntt_sol    (decomp_ntt_sol),
    .decomp_ntt_eol    (decomp_ntt_eol),
    .decomp_ntt_pbs_id (decomp_ntt_pbs_id)
  );

endmodule

// File: design/pbs_pkg.sv
`include "pbs_consts.svh"

package pbs_pkg;

  typedef logic [`PBS_MOD_Q_W-1:0]           coef_t;
  // Signed digit in two's complement, one bit wider than the base
  typedef logic [`PBS_B_W:0]                 digit_t;
  // Level 0 sits in the low bits
  typedef digit_t [`PBS_L-1:0]               decomp_t;
  typedef logic [$clog2(`PBS_SLOT_NB)-1:0]   slot_t;
  typedef logic [$clog2(`PBS_N)-1:0]         coef_idx_t;
  typedef logic [$clog2(2*`PBS_N)-1:0]       rot_t;
  typedef logic [`PBS_ID_W-1:0]              pbs_id_t;

  typedef struct packed {
    slot_t     slot;
    coef_idx_t idx;
  } ram_add_t;

  typedef enum logic {LDG_IDLE, LDG_DATA} ldg_state_e;
  typedef enum logic {MMACC_IDLE, MMACC_RUN} mmacc_state_e;

  typedef struct packed {
    logic ldg_cmd_ovf;
    logic ldg_data_unexp;
    logic mmacc_cmd_ovf;
  } pep_error_t;

endpackage

// File: testbench/tb_clk_gen.sv
`timescale 1ns/100ps

module tb_clk_gen #(
  parameter int PERIOD     = 40,
  parameter int RST_CYCLES = 2
) (
  output logic clk,
  output logic s_rst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD/2) clk = ~clk;
  end

  // Released just after an edge, like the rest of the stimulus
  initial begin
    s_rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    #5;
    s_rst_n = 1'b1;
  end

endmodule

// File: testbench/tb_pbs_entry_subs.sv
`timescale 1ns/100ps
`include "pbs_consts.svh"

module tb_pbs_entry_subs
  import pbs_pkg::*;
();

  localparam int TIMEOUT = 100;
  localparam int RADIX   = 1 << `PBS_B_W;
  localparam int ROUND_W = `PBS_L * `PBS_B_W;
  // Command cycle to first output beat
  localparam int LAT     = 4;

  logic       clk;
  logic       s_rst_n;
  logic       ldg_cmd_vld;
  slot_t      ldg_cmd_slot;
  logic       ldg_data_vld;
  coef_t      ldg_data;
  logic       ldg_cmd_done;
  logic       mmacc_cmd_vld;
  slot_t      mmacc_cmd_slot;
  rot_t       mmacc_cmd_rot;
  pbs_id_t    mmacc_cmd_pbs_id;
  logic       mmacc_cmd_ack;
  logic       decomp_ntt_avail;
  decomp_t    decomp_ntt_data;
  logic       decomp_ntt_sol;
  logic       decomp_ntt_eol;
  pbs_id_t    decomp_ntt_pbs_id;
  logic       pep_counter_inc;
  pep_error_t pep_error;

  coef_t       model_mem [`PBS_SLOT_NB][`PBS_N];
  coef_t       load_buf [`PBS_N];
  decomp_t     exp_data [$];
  pbs_id_t     exp_id [$];
  int          exp_idx [$];
  int          exp_cyc [$];
  logic [15:0] lfsr = 16'd38;
  string       cur_test;
  int          cyc = 0;
  int          err_cnt = 0;
  int          check_cnt = 0;
  int          test_cnt = 0;
  int          fail_cnt = 0;
  int          test_err_base = 0;
  int          done_cnt = 0;
  int          inc_cnt = 0;
  int          rot_list [4] = '{0, 1, 15, 16};
  // Targets for the decomposer: rounding carry, chunk of 8, wrap to zero
  int          edge_val [`PBS_N] = '{'h0000, 'h0080, 'h007E, 'h0800, 'h0780, 'h0700,
                                     'hFF80, 'hFF7E, 'h7F80, 'h8000, 'h7FFE, 'h0880,
                                     'h0F80, 'h8800, 'h7800, 'hFFFE};

  tb_clk_gen i_tb_clk_gen (
    .clk     (clk),
    .s_rst_n (s_rst_n)
  );

  pbs_entry_subs i_pbs_entry_subs (.*);

  always @(posedge clk) cyc <= cyc + 1;

  // ------------------------------
  // Random numbers and reference
  // ------------------------------
  function automatic logic [15:0] galois_step(logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] val;
    val = '0;
    for (int k = 0; k < n; k++) begin
      val  = {val[30:0], lfsr[0]};
      lfsr = galois_step(lfsr);
    end
    return val;
  endfunction

  function automatic coef_t ref_rotate_sub(slot_t s, rot_t p, int i);
    int    pp;
    int    j;
    logic  neg;
    coef_t r;
    pp  = int'(p);
    neg = 1'b0;
    if (pp >= `PBS_N) begin
      pp  = pp - `PBS_N;
      neg = 1'b1;
    end
    j = i - pp;
    if (j >= 0) r = model_mem[s][j];
    else r = coef_t'(0) - model_mem[s][j + `PBS_N];
    if (neg) r = coef_t'(0) - r;
    return r - model_mem[s][i];
  endfunction

  function automatic decomp_t ref_decomp(coef_t v);
    int      t;
    int      carry;
    int      chunk;
    decomp_t d;
    t = ((int'(v) >> (`PBS_MOD_Q_W - ROUND_W)) + ((int'(v) >> (`PBS_MOD_Q_W - ROUND_W - 1)) & 1))
        % (1 << ROUND_W);
    carry = 0;
    for (int l = 0; l < `PBS_L; l++) begin
      chunk = (((t >> (l * `PBS_B_W)) % RADIX) + carry) % RADIX;
      carry = (chunk >= RADIX / 2) ? 1 : 0;
      d[l]  = digit_t'(chunk - carry * RADIX);
    end
    return d;
  endfunction

  function automatic pep_error_t make_error(logic cmd_ovf, logic data_unexp, logic mm_ovf);
    pep_error_t e;
    e.ldg_cmd_ovf    = cmd_ovf;
    e.ldg_data_unexp = data_unexp;
    e.mmacc_cmd_ovf  = mm_ovf;
    return e;
  endfunction

  // ------------------------------
  // Compare tasks
  // ------------------------------
  task automatic compare_report(string what, logic ok, string exp_s, string act_s);
    check_cnt++;
    if (!ok) begin
      err_cnt++;
      $display("error %s: %s expected %s actual %s", cur_test, what, exp_s, act_s);
    end
  endtask

  task automatic check_decomp(string what, decomp_t exp, decomp_t act);
    compare_report(what, act === exp, $sformatf("%h", exp), $sformatf("%h", act));
  endtask

  task automatic check_pbs_id(string what, pbs_id_t exp, pbs_id_t act);
    compare_report(what, act === exp, $sformatf("%h", exp), $sformatf("%h", act));
  endtask

  task automatic check_error(string what, pep_error_t exp, pep_error_t act);
    compare_report(what, act === exp, $sformatf("%b", exp), $sformatf("%b", act));
  endtask

  task automatic check_flag(string what, logic exp, logic act);
    compare_report(what, act === exp, $sformatf("%b", exp), $sformatf("%b", act));
  endtask

  task automatic check_count(string what, int exp, int act);
    compare_report(what, act == exp, $sformatf("%0d", exp), $sformatf("%0d", act));
  endtask

  task automatic timeout_error(string what);
    err_cnt++;
    $display("timeout while waiting for %s in test %s", what, cur_test);
  endtask

  // Output beats are checked at the falling edge, away from the DUT updates
  always @(negedge clk) begin : monitor
    int k;
    if (s_rst_n) begin
      if (ldg_cmd_done) done_cnt++;
      if (pep_counter_inc) inc_cnt++;
      if (decomp_ntt_avail && exp_data.size() == 0) begin
        err_cnt++;
        $display("unexpected output beat at cycle %0d with no command pending", cyc);
      end else if (decomp_ntt_avail) begin
        k = exp_idx.pop_front();
        check_count($sformatf("beat %0d cycle", k), exp_cyc.pop_front(), cyc);
        check_decomp($sformatf("beat %0d digits", k), exp_data.pop_front(), decomp_ntt_data);
        check_flag($sformatf("beat %0d sol", k), k == 0, decomp_ntt_sol);
        check_flag($sformatf("beat %0d eol", k), k == `PBS_N - 1, decomp_ntt_eol);
        check_pbs_id($sformatf("beat %0d pbs id", k), exp_id.pop_front(), decomp_ntt_pbs_id);
      end
    end
  end

  // ------------------------------
  // Stimulus tasks
  // ------------------------------
  task automatic next_cycle();
    @(posedge clk);
    #5;
  endtask

  task automatic wait_until_cycle(int target);
    int n;
    n = 0;
    while (cyc < target && n < TIMEOUT) begin
      next_cycle();
      n++;
    end
    if (cyc < target) timeout_error("cycle count");
  endtask

  task automatic begin_test(string name);
    cur_test      = name;
    test_err_base = err_cnt;
    test_cnt++;
  endtask

  task automatic end_test();
    if (err_cnt == test_err_base) begin
      $display("test %s: ok", cur_test);
    end else begin
      fail_cnt++;
      $display("test %s: failed with %0d errors", cur_test, err_cnt - test_err_base);
    end
  endtask

  task automatic fill_random();
    for (int k = 0; k < `PBS_N; k++) load_buf[k] = coef_t'(rand_bits(`PBS_MOD_Q_W));
  endtask

  task automatic load_slot(slot_t s, bit gaps, bit second_cmd);
    int n;
    ldg_cmd_vld  = 1'b1;
    ldg_cmd_slot = s;
    next_cycle();
    // Optional second command toward the other slot, must be ignored
    ldg_cmd_vld  = second_cmd;
    ldg_cmd_slot = ~s;
    if (second_cmd) begin
      next_cycle();
      ldg_cmd_vld = 1'b0;
      check_error("error after second load command", make_error(1'b1, 1'b0, 1'b0), pep_error);
    end
    for (int k = 0; k < `PBS_N; k++) begin
      if (gaps) repeat (rand_bits(2)) next_cycle();
      ldg_data_vld    = 1'b1;
      ldg_data        = load_buf[k];
      model_mem[s][k] = load_buf[k];
      next_cycle();
      ldg_data_vld = 1'b0;
    end
    n = 1;
    while (!ldg_cmd_done && n < TIMEOUT) begin
      next_cycle();
      n++;
    end
    if (!ldg_cmd_done) begin
      timeout_error("load done");
    end else begin
      check_count("load done delay", 1, n);
      check_flag("counter inc with done", 1'b1, pep_counter_inc);
    end
  endtask

  task automatic start_mmacc(slot_t s, rot_t p, pbs_id_t id, output int cmd_cyc);
    int n;
    mmacc_cmd_vld    = 1'b1;
    mmacc_cmd_slot   = s;
    mmacc_cmd_rot    = p;
    mmacc_cmd_pbs_id = id;
    cmd_cyc          = cyc;
    for (int k = 0; k < `PBS_N; k++) begin
      exp_data.push_back(ref_decomp(ref_rotate_sub(s, p, k)));
      exp_id.push_back(id);
      exp_idx.push_back(k);
      exp_cyc.push_back(cmd_cyc + LAT + k);
    end
    next_cycle();
    mmacc_cmd_vld = 1'b0;
    n = 1;
    while (!mmacc_cmd_ack && n < TIMEOUT) begin
      next_cycle();
      n++;
    end
    if (!mmacc_cmd_ack) timeout_error("command ack");
    else check_count("ack delay", 1, n);
  endtask

  task automatic drain_stream();
    int n;
    n = 0;
    while (exp_data.size() != 0 && n < TIMEOUT) begin
      next_cycle();
      n++;
    end
    if (exp_data.size() != 0) begin
      timeout_error("output stream");
      exp_data.delete();
      exp_id.delete();
      exp_idx.delete();
      exp_cyc.delete();
    end else begin
      check_flag("avail after stream", 1'b0, decomp_ntt_avail);
    end
  endtask

  task automatic run_mmacc(slot_t s, rot_t p, pbs_id_t id);
    int c;
    start_mmacc(s, p, id, c);
    drain_stream();
  endtask

  // ------------------------------
  // Test sequence
  // ------------------------------
  initial begin : stimulus
    int   c;
    int   n;
    int   d0;
    int   i0;
    rot_t p;
    ldg_cmd_vld      = 1'b0;
    ldg_cmd_slot     = '0;
    ldg_data_vld     = 1'b0;
    ldg_data         = '0;
    mmacc_cmd_vld    = 1'b0;
    mmacc_cmd_slot   = '0;
    mmacc_cmd_rot    = '0;
    mmacc_cmd_pbs_id = '0;
    cur_test         = "reset";
    // Reset level is sampled on the rising edge
    n = 0;
    while (s_rst_n !== 1'b1 && n < TIMEOUT) begin
      @(posedge clk);
      n++;
    end
    #5;
    if (s_rst_n !== 1'b1) timeout_error("reset release");

    begin_test("reset_values");
    check_flag("ack", 1'b0, mmacc_cmd_ack);
    check_flag("load done", 1'b0, ldg_cmd_done);
    check_flag("avail", 1'b0, decomp_ntt_avail);
    check_flag("counter inc", 1'b0, pep_counter_inc);
    check_error("error word", make_error(1'b0, 1'b0, 1'b0), pep_error);
    end_test();

    begin_test("load_slots");
    d0 = done_cnt;
    i0 = inc_cnt;
    for (int s = 0; s < `PBS_SLOT_NB; s++) begin
      fill_random();
      load_slot(slot_t'(s), 1'b1, 1'b0);
    end
    next_cycle();
    check_count("done pulses", d0 + `PBS_SLOT_NB, done_cnt);
    check_count("counter pulses", i0 + `PBS_SLOT_NB, inc_cnt);
    end_test();

    begin_test("rotate_sub");
    for (int s = 0; s < `PBS_SLOT_NB; s++) begin
      for (int r = 0; r < 6; r++) begin
        p = (r < 4) ? rot_t'(rot_list[r]) : rot_t'(rand_bits(5));
        run_mmacc(slot_t'(s), p, pbs_id_t'(rand_bits(`PBS_ID_W)));
      end
    end
    end_test();

    // Second command at the earliest cycle allowed
    begin_test("timing");
    start_mmacc(1'b1, rot_t'(rand_bits(5)), pbs_id_t'(rand_bits(`PBS_ID_W)), c);
    wait_until_cycle(c + `PBS_N + 1);
    start_mmacc(1'b0, rot_t'(rand_bits(5)), pbs_id_t'(rand_bits(`PBS_ID_W)), c);
    drain_stream();
    end_test();

    // Rotation by N gives -2*g[i], so g is picked to hit each target
    begin_test("decomp_edges");
    for (int k = 0; k < `PBS_N; k++) load_buf[k] = coef_t'((65536 - edge_val[k]) / 2);
    load_slot(1'b0, 1'b0, 1'b0);
    run_mmacc(1'b0, rot_t'(`PBS_N), 4'hA);
    end_test();

    begin_test("error_flags");
    ldg_data_vld = 1'b1;
    ldg_data     = 16'h1234;
    next_cycle();
    ldg_data_vld = 1'b0;
    check_error("error after stray data", make_error(1'b0, 1'b1, 1'b0), pep_error);
    next_cycle();
    check_error("error cleared", make_error(1'b0, 1'b0, 1'b0), pep_error);
    fill_random();
    load_slot(1'b1, 1'b0, 1'b1);
    start_mmacc(1'b1, rot_t'(3), 4'h5, c);
    wait_until_cycle(c + 5);
    mmacc_cmd_vld    = 1'b1;
    mmacc_cmd_slot   = 1'b0;
    mmacc_cmd_rot    = rot_t'(7);
    mmacc_cmd_pbs_id = 4'h9;
    next_cycle();
    mmacc_cmd_vld = 1'b0;
    check_error("error after command in run", make_error(1'b0, 1'b0, 1'b1), pep_error);
    check_flag("ack for ignored command", 1'b0, mmacc_cmd_ack);
    drain_stream();
    end_test();

    $display("%0d tests, %0d passed, %0d failed, %0d checks, %0d errors",
             test_cnt, test_cnt - fail_cnt, fail_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule
